//--- logic/vid_macros.svh
// Video geometry and memory constants
`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

// raster, in clocks and lines.
`define H_TOTAL     64
`define H_VISIBLE   32
`define V_TOTAL     12
`define V_VISIBLE   8

`define FIFO_DEPTH  8

// screen lives in video RAM from here on.
`define SCREEN_BASE 10'h100
`define FRAME_WORDS ((`H_VISIBLE / 8) * `V_VISIBLE)

`define VRAM_AW     10
`define VRAM_DW     16

`endif

//--- logic/vid_pkg.sv
// Video subsystem types
`include "vid_macros.svh"

package vid_pkg;

	// one memory word, also one group of four pixels.
	typedef logic [`VRAM_DW-1:0] word_t;

	typedef logic [`VRAM_AW-1:0] vaddr_t;

	typedef logic [3:0] pixel_t;

	// the four clocks of one memory slot.
	typedef enum logic [1:0]
	{
		PH_C0,
		PH_C1,
		PH_C2,
		PH_C3
	} slot_phase_t;

	typedef enum logic [1:0]
	{
		SLOT_IDLE,
		SLOT_CPU,
		SLOT_VIDEO
	} slot_owner_t;

endpackage

//--- logic/beam_sync.sv
// Raster beam counters
`include "vid_macros.svh"

module beam_sync (
	input  logic clk,
	input  logic arst_n,
	output logic vsync,
	output logic line_visible,
	output logic pixel_active
);

	localparam int HW = $clog2(`H_TOTAL);
	localparam int VW = $clog2(`V_TOTAL);

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic          line_end;

	assign line_end = (hcnt == HW'(`H_TOTAL - 1));

	// start in the sync line so the first frame gets its prefill.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hcnt <= '0;
			vcnt <= VW'(`V_VISIBLE);
		end
		else
		begin
			if (line_end)
				hcnt <= '0;
			else
				hcnt <= hcnt + 1'b1;

			if (line_end)
			begin
				if (vcnt == VW'(`V_TOTAL - 1))
					vcnt <= '0;
				else
					vcnt <= vcnt + 1'b1;
			end
		end
	end

	assign vsync        = (vcnt == VW'(`V_VISIBLE)); // first line below the picture.
	assign line_visible = (vcnt < VW'(`V_VISIBLE));
	assign pixel_active = line_visible && (hcnt < HW'(`H_VISIBLE));

endmodule

//--- logic/vram.sv
// Video RAM array
`include "vid_macros.svh"

module vram (
	input  logic            clk,
	input  logic            mem_we,
	input  vid_pkg::vaddr_t mem_addr,
	input  vid_pkg::word_t  mem_wrdata,
	output vid_pkg::word_t  mem_rddata
);

	import vid_pkg::*;

	localparam int WORDS = 2 ** `VRAM_AW;

	word_t mem [WORDS];

	// read returns the word as it was before a write in the same clock.
	always_ff @(posedge clk)
	begin
		if (mem_we)
			mem[mem_addr] <= mem_wrdata;
		mem_rddata <= mem[mem_addr];
	end

endmodule

//--- logic/dram_arbiter.sv
// Memory slot sequencer
`include "vid_macros.svh"

module dram_arbiter (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            vsync,
	input  logic            room,
	input  logic            cpu_req,
	input  logic            cpu_rnw,
	input  vid_pkg::vaddr_t cpu_addr,
	input  vid_pkg::word_t  cpu_wrdata,
	output vid_pkg::word_t  cpu_rddata,
	output logic            cpu_strobe,
	output logic            mem_we,
	output vid_pkg::vaddr_t mem_addr,
	output vid_pkg::word_t  mem_wrdata,
	input  vid_pkg::word_t  mem_rddata,
	output vid_pkg::word_t  video_data,
	output logic            video_strobe
);

	import vid_pkg::*;

	localparam vaddr_t FETCH_END = vaddr_t'(`SCREEN_BASE + `FRAME_WORDS);

	slot_phase_t phase;
	slot_owner_t owner;
	vaddr_t      fetch_ptr;
	word_t       rd_q;
	logic        vsync_q;
	logic        frame_start;
	logic        fetch_due;

	assign frame_start = vsync && !vsync_q;
	assign fetch_due   = room && (fetch_ptr < FETCH_END);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			phase <= PH_C0;
		else
		begin
			case (phase)
				PH_C0: phase <= PH_C1;
				PH_C1: phase <= PH_C2;
				PH_C2: phase <= PH_C3;
				default: phase <= PH_C0;
			endcase
		end
	end

	// video has priority, the cpu takes what is left.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			owner <= SLOT_IDLE;
		else if (phase == PH_C0)
		begin
			if (fetch_due)
				owner <= SLOT_VIDEO;
			else if (cpu_req)
				owner <= SLOT_CPU;
			else
				owner <= SLOT_IDLE;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vsync_q   <= 1'b0;
			fetch_ptr <= `SCREEN_BASE;
		end
		else
		begin
			vsync_q <= vsync;
			if (frame_start)
				fetch_ptr <= `SCREEN_BASE;
			else if (phase == PH_C3 && owner == SLOT_VIDEO)
				fetch_ptr <= fetch_ptr + 1'b1; // word done, move on.
		end
	end

	assign mem_addr   = (owner == SLOT_CPU) ? cpu_addr : fetch_ptr;
	assign mem_we     = (phase == PH_C1) && (owner == SLOT_CPU) && !cpu_rnw;
	assign mem_wrdata = cpu_wrdata;

	// data from the c1 address shows up during c2.
	always_ff @(posedge clk)
	begin
		if (phase == PH_C2)
			rd_q <= mem_rddata;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cpu_strobe   <= 1'b0;
			video_strobe <= 1'b0;
		end
		else
		begin
			cpu_strobe   <= (phase == PH_C2) && (owner == SLOT_CPU);
			video_strobe <= (phase == PH_C2) && (owner == SLOT_VIDEO);
		end
	end

	assign cpu_rddata = rd_q;
	assign video_data = rd_q;

endmodule

//--- logic/fetch_fifo.sv
// Video fetch buffer
`include "vid_macros.svh"

module fetch_fifo (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           vsync,
	input  logic           video_strobe,
	input  vid_pkg::word_t video_data,
	input  logic           video_next,
	output vid_pkg::word_t fifo_data,
	output logic           room
);

	import vid_pkg::*;

	localparam int PW = $clog2(`FIFO_DEPTH);

	word_t         buf_q [`FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0]   count;
	logic          vsync_q;
	logic          clear;

	assign clear     = vsync && !vsync_q; // each frame starts from an empty buffer.
	assign room      = (count <= (PW + 1)'(`FIFO_DEPTH - 2));
	assign fifo_data = buf_q[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (video_strobe)
			buf_q[wr_ptr] <= video_data;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vsync_q <= 1'b0;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
		end
		else
		begin
			vsync_q <= vsync;
			if (clear)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end
			else
			begin
				if (video_strobe)
					wr_ptr <= wr_ptr + 1'b1;
				if (video_next)
					rd_ptr <= rd_ptr + 1'b1;
				if (video_strobe && !video_next)
					count <= count + 1'b1;
				else if (!video_strobe && video_next)
					count <= count - 1'b1;
			end
		end
	end

endmodule

//--- logic/pixel_shift.sv
// Pixel serializer
module pixel_shift (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            pixel_active,
	input  vid_pkg::word_t  fifo_data,
	output logic            video_next,
	output logic            pix_valid,
	output vid_pkg::pixel_t pix
);

	import vid_pkg::*;

	localparam int DW = $bits(word_t);
	localparam int PW = $bits(pixel_t);

	logic [2:0] sub; // two clocks per pixel, four pixels per word.
	word_t      shreg;

	assign video_next = pixel_active && (sub == 3'd0);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sub       <= '0;
			pix_valid <= 1'b0;
			pix       <= '0;
		end
		else
		begin
			pix_valid <= pixel_active;
			if (!pixel_active)
			begin
				sub <= '0;
				pix <= '0;
			end
			else
			begin
				sub <= sub + 3'd1;
				if (sub == 3'd0)
					pix <= fifo_data[DW-1 -: PW]; // top nibble goes first.
				else if (!sub[0])
					pix <= shreg[DW-1 -: PW];
			end
		end
	end

	// remaining nibbles of the current word, next one on top.
	always_ff @(posedge clk)
	begin
		if (video_next)
			shreg <= fifo_data << PW;
		else if (pixel_active && !sub[0])
			shreg <= shreg << PW;
	end

endmodule

//--- logic/vid_top.sv
// Video memory subsystem
module vid_top (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            cpu_req,
	input  logic            cpu_rnw,
	input  vid_pkg::vaddr_t cpu_addr,
	input  vid_pkg::word_t  cpu_wrdata,
	output vid_pkg::word_t  cpu_rddata,
	output logic            cpu_strobe,
	output logic            vsync,
	output logic            pix_valid,
	output vid_pkg::pixel_t pix
);

	import vid_pkg::*;

	logic   pixel_active;
	logic   room;
	logic   mem_we;
	vaddr_t mem_addr;
	word_t  mem_wrdata;
	word_t  mem_rddata;
	word_t  video_data;
	logic   video_strobe;
	logic   video_next;
	word_t  fifo_data;

	beam_sync beam0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.vsync        (vsync),
		.line_visible (),
		.pixel_active (pixel_active)
	);

	vram vram0 (
		.clk        (clk),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wrdata (mem_wrdata),
		.mem_rddata (mem_rddata)
	);

	dram_arbiter arb0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.vsync        (vsync),
		.room         (room),
		.cpu_req      (cpu_req),
		.cpu_rnw      (cpu_rnw),
		.cpu_addr     (cpu_addr),
		.cpu_wrdata   (cpu_wrdata),
		.cpu_rddata   (cpu_rddata),
		.cpu_strobe   (cpu_strobe),
		.mem_we       (mem_we),
		.mem_addr     (mem_addr),
		.mem_wrdata   (mem_wrdata),
		.mem_rddata   (mem_rddata),
		.video_data   (video_data),
		.video_strobe (video_strobe)
	);

	fetch_fifo fifo0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.vsync        (vsync),
		.video_strobe (video_strobe),
		.video_data   (video_data),
		.video_next   (video_next),
		.fifo_data    (fifo_data),
		.room         (room)
	);

	pixel_shift shift0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.pixel_active (pixel_active),
		.fifo_data    (fifo_data),
		.video_next   (video_next),
		.pix_valid    (pix_valid),
		.pix          (pix)
	);

endmodule

//--- dv/vid_props.sv
// Slot and buffer assertions
`include "vid_macros.svh"

module vid_props (
	input logic                          clk,
	input logic                          arst_n,
	input logic                          cpu_strobe,
	input logic                          video_strobe,
	input logic                          slot_c0,
	input logic                          cpu_req,
	input logic                          room,
	input logic                          push,
	input logic                          pop,
	input logic [$clog2(`FIFO_DEPTH):0]  level
);

	// one owner per slot.
	assert property (@(posedge clk) disable iff (!arst_n) !(cpu_strobe && video_strobe))
		else $error("cpu and video strobes high together");

	// a strobe closes the slot granted at the c0 three clocks earlier.
	assert property (@(posedge clk) disable iff (!arst_n)
		cpu_strobe |-> $past(slot_c0 && cpu_req, 3))
		else $error("cpu strobe without a cpu request at the c0 three clocks before");

	assert property (@(posedge clk) disable iff (!arst_n)
		video_strobe |-> $past(slot_c0 && room, 3))
		else $error("video strobe without buffer room at the c0 three clocks before");

	assert property (@(posedge clk) disable iff (!arst_n)
		(push && !pop) |-> (level < `FIFO_DEPTH))
		else $error("fetch buffer overflow");

	assert property (@(posedge clk) disable iff (!arst_n) pop |-> (level != '0))
		else $error("fetch buffer popped while empty");

endmodule

bind dram_arbiter vid_props props_arb (
	.clk          (clk),
	.arst_n       (arst_n),
	.cpu_strobe   (cpu_strobe),
	.video_strobe (video_strobe),
	.slot_c0      (phase == vid_pkg::PH_C0),
	.cpu_req      (cpu_req),
	.room         (room),
	.push         (1'b0),
	.pop          (1'b0),
	.level        ('0)
);

bind fetch_fifo vid_props props_fifo (
	.clk          (clk),
	.arst_n       (arst_n),
	.cpu_strobe   (1'b0),
	.video_strobe (1'b0),
	.slot_c0      (1'b0),
	.cpu_req      (1'b0),
	.room         (1'b0),
	.push         (video_strobe),
	.pop          (video_next),
	.level        (count)
);

//--- dv/vid_tb.sv
// Video subsystem testbench
`include "vid_macros.svh"

module vid_tb;

	import vid_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int MAX_CMDS   = 64;
	localparam int CW         = $clog2(MAX_CMDS);
	localparam int WORDS      = 2 ** `VRAM_AW;
	localparam int FRAME_SAMPLES = `FRAME_WORDS * 8; // four pixels per word, two clocks each.

	logic   clk = 1'b0;
	logic   arst_n;
	logic   cpu_req;
	logic   cpu_rnw;
	vaddr_t cpu_addr;
	word_t  cpu_wrdata;
	word_t  cpu_rddata;
	logic   cpu_strobe;
	logic   vsync;
	logic   pix_valid;
	pixel_t pix;

	logic [31:0] trace [MAX_CMDS] = '{default: 32'h0};
	int          n_cmds;
	logic        trace_loaded = 1'b0;
	word_t       shadow [WORDS];
	logic        written [WORDS] = '{default: 1'b0};
	int          errors = 0;
	int          frames_checked = 0;

	vid_top dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.cpu_req    (cpu_req),
		.cpu_rnw    (cpu_rnw),
		.cpu_addr   (cpu_addr),
		.cpu_wrdata (cpu_wrdata),
		.cpu_rddata (cpu_rddata),
		.cpu_strobe (cpu_strobe),
		.vsync      (vsync),
		.pix_valid  (pix_valid),
		.pix        (pix)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_error(input string msg);
		errors++;
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_pixel(input string name, input pixel_t expected,
		input pixel_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	// one clock, then settle past the edge before looking or driving.
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	function automatic word_t fill_value(input vaddr_t a);
		return {a[5:0], a} ^ 16'h5a3c;
	endfunction

	// hold the request until the strobe, data is valid with it.
	task automatic cpu_access(input logic rnw, input vaddr_t addr, input word_t wdata,
		output word_t rdata);
		cpu_req    = 1'b1;
		cpu_rnw    = rnw;
		cpu_addr   = addr;
		cpu_wrdata = wdata;
		do
			tick();
		while (!cpu_strobe);
		rdata   = cpu_rddata;
		cpu_req = 1'b0;
	endtask

	task automatic cpu_write(input vaddr_t addr, input word_t data);
		word_t rd;
		cpu_access(1'b0, addr, data, rd);
		shadow[addr]  = data;
		written[addr] = 1'b1;
	endtask

	task automatic cpu_read(input vaddr_t addr, input word_t trace_data);
		word_t rd;
		if (!written[addr])
			stop_on_error($sformatf("trace reads address %h before any write to it", addr));
		if (trace_data !== shadow[addr])
			stop_on_error($sformatf("trace expects %h at %h but the shadow memory holds %h",
				trace_data, addr, shadow[addr]));
		cpu_access(1'b1, addr, '0, rd);
		check_word($sformatf("cpu read %h", addr), shadow[addr], rd);
	endtask

	// every screen word gets a known value before the trace starts.
	task automatic fill_screen();
		vaddr_t a;
		for (int i = 0; i < `FRAME_WORDS; i++)
		begin
			a = vaddr_t'(`SCREEN_BASE + i);
			repeat ($urandom % 4) tick();
			cpu_write(a, fill_value(a));
		end
	endtask

	task automatic frame_check(input string name);
		logic   prev;
		logic   rose;
		int     k;
		word_t  w;
		pixel_t exp_pix;
		prev = vsync;
		rose = 1'b0;
		while (!rose)
		begin
			tick();
			rose = vsync && !prev;
			prev = vsync;
		end
		k = 0;
		while (k < FRAME_SAMPLES)
		begin
			tick();
			if (pix_valid)
			begin
				w       = shadow[vaddr_t'(`SCREEN_BASE + k / 8)];
				exp_pix = pixel_t'(w >> (4 * (3 - (k / 2) % 4))); // high nibble first.
				check_pixel($sformatf("%s pixel %0d", name, k / 2), exp_pix, pix);
				k++;
			end
		end
	endtask

	task automatic run_command(input logic [31:0] cmd);
		logic [3:0] op;
		vaddr_t     addr;
		word_t      data;
		op   = cmd[31:28];
		addr = vaddr_t'(cmd[27:16]);
		data = cmd[15:0];
		repeat ($urandom % 4) tick();
		case (op)
			4'h1: cpu_write(addr, data);
			4'h2: cpu_read(addr, data);
			4'hf:
			begin
				frames_checked++;
				frame_check($sformatf("frame check %0d", frames_checked));
			end
			default: stop_on_error($sformatf("unknown trace command %h", cmd));
		endcase
	endtask

	initial
	begin
		int i;
		void'($urandom(80389));
		arst_n     = 1'b0;
		cpu_req    = 1'b0;
		cpu_rnw    = 1'b1;
		cpu_addr   = '0;
		cpu_wrdata = '0;
		$readmemh("dv/vid_trace.txt", trace);
		n_cmds = 0;
		while (n_cmds < MAX_CMDS && trace[CW'(n_cmds)][31:28] != 4'h0)
			n_cmds++;
		if (n_cmds == 0)
			stop_on_error("trace file holds no commands");
		trace_loaded = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
		fill_screen();
		for (i = 0; i < n_cmds; i++)
			run_command(trace[CW'(i)]);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// two frames per trace command is far more than any command needs.
	initial
	begin
		wait (trace_loaded);
		#(longint'(n_cmds) * 2 * `H_TOTAL * `V_TOTAL * CLK_PERIOD);
		$display("watchdog expired before the trace finished");
		$display("TB FAILED");
		$fatal(1, "run stopped by the watchdog");
	end

endmodule

//--- dv/vid_trace.txt
// columns: op (1 write, 2 read with expected data, f frame check), address, data
// screen words 100 to 11f hold a fill pattern before the first command
1_010_1234
1_3ff_c0de
1_104_fedc
2_010_1234
1_105_0f1e
2_104_fedc
2_3ff_c0de
f_000_0000
1_100_9876
1_11f_a5a5
2_105_0f1e
2_100_9876
f_000_0000
2_11f_a5a5

//--- vlog.f
+incdir+logic
logic/vid_pkg.sv
logic/beam_sync.sv
logic/vram.sv
logic/dram_arbiter.sv
logic/fetch_fifo.sv
logic/pixel_shift.sv
logic/vid_top.sv
dv/vid_props.sv
dv/vid_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module vid_tb -f vlog.f > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/Vvid_tb > sim.log 2>&1
grep -qx "TB PASSED" sim.log && echo "simulation passed" \
	|| { cat sim.log; echo "simulation failed"; exit 1; }
